// ==== logic/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data memory size in 32-bit words
// word index is taken from the address bits above the byte offset
`define DMEM_WORDS 64

// worst case memory response latency in cycles, at least 1
`define DMEM_MAX_LAT 4

// width of the retire order tag
`define ORDER_W 16

`endif

// ==== logic/rv32i_types.sv ====
`default_nettype none

`include "core_settings.svh"

package rv32i_types;

    // funct3 of the RV32I load and store instructions
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } mem_funct3_t;

    // stores share the size encodings of the signed loads
    localparam mem_funct3_t sb = lb;
    localparam mem_funct3_t sh = lh;
    localparam mem_funct3_t sw = lw;

    typedef struct packed {
        logic                valid;
        logic [`ORDER_W-1:0] order;     // program order of the operation
        mem_funct3_t         funct3;
        logic                mem_read;
        logic                mem_write;
        logic                regf_we;
        logic [4:0]          rd_s;
        logic [31:0]         alu_result; // effective address for memory ops
        logic [31:0]         rs2_v;      // store data
    } ex_mem_reg_t;

    // retire record, keeps only what a memory checker looks at
    typedef struct packed {
        logic                valid;
        logic [`ORDER_W-1:0] order;
        logic                regf_we;
        logic [4:0]          rd_s;
        logic [31:0]         rd_v;
        logic [31:0]         mem_addr;  // word aligned
        logic [3:0]          mem_rmask;
        logic [3:0]          mem_wmask;
        logic [31:0]         mem_wdata;
    } mem_wb_reg_t;

endpackage

`default_nettype wire

// ==== logic/dmem_bus_pkg.sv ====
`default_nettype none

package dmem_bus_pkg;

    // a request is present while either mask is nonzero
    typedef struct packed {
        logic [31:0] addr;  // low two bits always zero
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } dmem_req_t;

    // resp is high for exactly one cycle per accepted request
    typedef struct packed {
        logic        resp;
        logic [31:0] rdata;
    } dmem_rsp_t;

endpackage

`default_nettype wire

// ==== logic/pipe_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_reg
#(
    parameter type record_t = logic [31:0]
)
(
    input  logic    clk,
    input  logic    rst,
    input  logic    hold,   // keep the current record
    input  logic    bubble, // load an empty record instead of d
    input  record_t d,
    output record_t q
);

    // hold has priority over bubble so a held record is never lost
    always_ff @(posedge clk)
    begin
        if (rst || (bubble && !hold))
        begin
            q <= '0;
        end
        else if (!hold)
        begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_stage
(
    input  rv32i_types::ex_mem_reg_t ex_mem_reg,
    output dmem_bus_pkg::dmem_req_t  dmem_req,
    input  dmem_bus_pkg::dmem_rsp_t  dmem_rsp,
    output logic                     stall,
    output rv32i_types::mem_wb_reg_t mem_wb_reg_next
);

    logic        is_load;
    logic        is_store;
    logic        is_mem;
    logic [1:0]  offset;
    logic [31:0] word_addr;
    logic [3:0]  rmask;
    logic [3:0]  wmask;
    logic [31:0] wdata;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    logic [31:0] load_v;

    assign is_load   = ex_mem_reg.valid && ex_mem_reg.mem_read;
    assign is_store  = ex_mem_reg.valid && ex_mem_reg.mem_write;
    assign is_mem    = is_load || is_store;
    assign offset    = ex_mem_reg.alu_result[1:0];
    assign word_addr = {ex_mem_reg.alu_result[31:2], 2'b00};

    // hold the operation here until the memory answers
    assign stall = is_mem && !dmem_rsp.resp;

    always_comb
    begin
        rmask = '0;
        if (is_load)
        begin
            unique case (ex_mem_reg.funct3)
                rv32i_types::lb, rv32i_types::lbu: rmask = 4'b0001 << offset;
                rv32i_types::lh, rv32i_types::lhu: rmask = 4'b0011 << offset;
                rv32i_types::lw:                   rmask = 4'b1111;
                default:                           rmask = '0;
            endcase
        end
    end

    // store byte or half goes into its own lane, other lanes stay zero
    always_comb
    begin
        wmask = '0;
        wdata = '0;
        if (is_store)
        begin
            unique case (ex_mem_reg.funct3)
                rv32i_types::sb:
                begin
                    wmask                = 4'b0001 << offset;
                    wdata[8*offset +: 8] = ex_mem_reg.rs2_v[7:0];
                end
                rv32i_types::sh:
                begin
                    wmask                      = 4'b0011 << offset;
                    wdata[16*offset[1] +: 16]  = ex_mem_reg.rs2_v[15:0];
                end
                rv32i_types::sw:
                begin
                    wmask = 4'b1111;
                    wdata = ex_mem_reg.rs2_v;
                end
                default:
                begin
                    wmask = '0;
                    wdata = '0;
                end
            endcase
        end
    end

    // request stays steady until the response cycle
    assign dmem_req.addr  = is_mem ? word_addr : '0;
    assign dmem_req.rmask = rmask;
    assign dmem_req.wmask = wmask;
    assign dmem_req.wdata = wdata;

    assign lane_b = dmem_rsp.rdata[8*offset +: 8];
    assign lane_h = dmem_rsp.rdata[16*offset[1] +: 16];

    always_comb
    begin
        unique case (ex_mem_reg.funct3)
            rv32i_types::lb:  load_v = {{24{lane_b[7]}}, lane_b};
            rv32i_types::lbu: load_v = {24'b0, lane_b};
            rv32i_types::lh:  load_v = {{16{lane_h[15]}}, lane_h};
            rv32i_types::lhu: load_v = {16'b0, lane_h};
            rv32i_types::lw:  load_v = dmem_rsp.rdata;
            default:          load_v = '0;
        endcase
    end

    always_comb
    begin
        mem_wb_reg_next.valid     = ex_mem_reg.valid; // stall bubbles this downstream
        mem_wb_reg_next.order     = ex_mem_reg.order;
        mem_wb_reg_next.regf_we   = ex_mem_reg.regf_we;
        mem_wb_reg_next.rd_s      = ex_mem_reg.rd_s;
        mem_wb_reg_next.rd_v      = is_load ? load_v : ex_mem_reg.alu_result;
        mem_wb_reg_next.mem_addr  = is_mem ? word_addr : '0;
        mem_wb_reg_next.mem_rmask = rmask;
        mem_wb_reg_next.mem_wmask = wmask;
        mem_wb_reg_next.mem_wdata = wdata;
    end

endmodule

`default_nettype wire

// ==== logic/data_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module data_mem
(
    input  logic                    clk,
    input  logic                    rst,
    input  dmem_bus_pkg::dmem_req_t req,
    output dmem_bus_pkg::dmem_rsp_t rsp
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);
    localparam int CNT_W = $clog2(`DMEM_MAX_LAT + 1);

    logic [31:0]             mem [`DMEM_WORDS];
    logic [3:0]              lfsr;   // latency source, x^4 + x^3 + 1
    logic                    busy;
    logic [CNT_W-1:0]        cnt;    // cycles left before the response cycle
    dmem_bus_pkg::dmem_req_t held;
    logic                    req_present;
    logic                    done;
    logic [IDX_W-1:0]        idx;

    assign req_present = (|req.rmask) || (|req.wmask);
    assign done        = busy && (cnt == '0);
    assign idx         = held.addr[IDX_W+1:2];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lfsr <= 4'b1001;
            busy <= 1'b0;
            cnt  <= '0;
        end
        else
        begin
            lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
            if (!busy)
            begin
                if (req_present)
                begin
                    busy <= 1'b1;
                    cnt  <= CNT_W'(lfsr % `DMEM_MAX_LAT); // latency is cnt + 1
                end
            end
            else if (done)
                busy <= 1'b0;
            else
                cnt <= cnt - 1'b1;
        end
    end

    // latch on acceptance, write at the end of the response cycle
    always_ff @(posedge clk)
    begin
        if (!busy && req_present)
            held <= req;
        if (done)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (held.wmask[i])
                    mem[idx][8*i +: 8] <= held.wdata[8*i +: 8];
            end
        end
    end

    assign rsp.resp  = done;
    assign rsp.rdata = done ? mem[idx] : '0;

endmodule

`default_nettype wire

// ==== logic/mem_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem
(
    input  logic                     clk,
    input  logic                     rst,
    input  rv32i_types::ex_mem_reg_t ex_in,
    output logic                     stall,
    output rv32i_types::mem_wb_reg_t wb_out
);

    rv32i_types::ex_mem_reg_t ex_mem_q;
    rv32i_types::mem_wb_reg_t mem_wb_next;
    dmem_bus_pkg::dmem_req_t  dmem_req;
    dmem_bus_pkg::dmem_rsp_t  dmem_rsp;

    pipe_reg #(.record_t(rv32i_types::ex_mem_reg_t)) u_ex_mem (
        .clk    (clk),
        .rst    (rst),
        .hold   (stall),        // keep the memory op until its response
        .bubble (1'b0),
        .d      (ex_in),
        .q      (ex_mem_q)
    );

    mem_stage u_mem_stage (
        .ex_mem_reg      (ex_mem_q),
        .dmem_req        (dmem_req),
        .dmem_rsp        (dmem_rsp),
        .stall           (stall),
        .mem_wb_reg_next (mem_wb_next)
    );

    data_mem u_data_mem (
        .clk (clk),
        .rst (rst),
        .req (dmem_req),
        .rsp (dmem_rsp)
    );

    pipe_reg #(.record_t(rv32i_types::mem_wb_reg_t)) u_mem_wb (
        .clk    (clk),
        .rst    (rst),
        .hold   (1'b0),
        .bubble (stall),        // one retire per op even when stalled
        .d      (mem_wb_next),
        .q      (wb_out)
    );

endmodule

`default_nettype wire

// ==== tb/mem_subsystem_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module mem_subsystem_tb;

    localparam int NUM_OPS     = 400;
    localparam int WATCHDOG_NS = (NUM_OPS + `DMEM_WORDS) * (`DMEM_MAX_LAT + 2) * 4 + 200;

    // test index doubles as the op kind for alu, store and load
    localparam int T_RESET = 0;
    localparam int T_ALU   = 1;
    localparam int T_STORE = 2;
    localparam int T_LOAD  = 3;
    localparam int T_RAW   = 4;
    localparam int T_ORDER = 5;

    logic                       clk = 1'b0;
    logic                       rst;
    rv32i_types::ex_mem_reg_t   ex_in;
    logic                       stall;
    rv32i_types::mem_wb_reg_t   wb_out;

    integer                     seed = 57;
    logic [7:0]                 model [`DMEM_WORDS*4];                   // byte image of the memory
    logic                       stored [`DMEM_WORDS] = '{default: 1'b0}; // stored to after the fill
    rv32i_types::mem_wb_reg_t   exp_q[$];
    int                         cat_q[$];
    int                         checks [6];
    int                         fails [6];
    logic [`ORDER_W-1:0]        tag;
    rv32i_types::mem_funct3_t   load_f3 [5] = '{rv32i_types::lb, rv32i_types::lh,
                                                rv32i_types::lw, rv32i_types::lbu,
                                                rv32i_types::lhu};
    rv32i_types::mem_funct3_t   store_f3 [3] = '{rv32i_types::sb, rv32i_types::sh,
                                                 rv32i_types::sw};

    mem_subsystem UUT (
        .clk    (clk),
        .rst    (rst),
        .ex_in  (ex_in),
        .stall  (stall),
        .wb_out (wb_out)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // bytes touched by an access as given by the funct3 size bits
    function automatic int access_bytes(input logic [2:0] f3);
        return (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
    endfunction

    function automatic rv32i_types::ex_mem_reg_t make_op(input int kind);
        rv32i_types::ex_mem_reg_t op;
        int                       n;
        op            = '0;
        op.valid      = 1'b1;
        op.order      = tag;
        op.rd_s       = 5'(next_rand());
        op.rs2_v      = next_rand();
        op.alu_result = next_rand();
        op.funct3     = rv32i_types::lw;
        op.regf_we    = (kind != T_STORE);
        op.mem_read   = (kind == T_LOAD);
        op.mem_write  = (kind == T_STORE);
        if (kind == T_LOAD)
            op.funct3 = load_f3[next_rand() % 5];
        if (kind == T_STORE)
            op.funct3 = store_f3[next_rand() % 3];
        if (kind != T_ALU)
        begin
            n             = access_bytes(op.funct3);
            op.alu_result = 4 * (next_rand() % `DMEM_WORDS) + n * (next_rand() % (4 / n));
        end
        return op;
    endfunction

    function automatic rv32i_types::mem_wb_reg_t expect_retire(
        input rv32i_types::ex_mem_reg_t op
    );
        rv32i_types::mem_wb_reg_t r;
        logic [2:0]               f3;
        logic [31:0]              v;
        int                       n;
        int                       off;
        int                       base;
        f3        = op.funct3;
        n         = access_bytes(f3);
        off       = op.alu_result[1:0];
        base      = op.alu_result - off;
        v         = '0;
        r         = '0;
        r.valid   = 1'b1;
        r.order   = op.order;
        r.regf_we = op.regf_we;
        r.rd_s    = op.rd_s;
        r.rd_v    = op.alu_result;
        if (op.mem_read || op.mem_write)
        begin
            r.mem_addr = base;
            for (int k = 0; k < n; k++)
            begin
                if (op.mem_write)
                begin
                    r.mem_wmask[off+k]          = 1'b1;
                    r.mem_wdata[8*(off+k) +: 8] = op.rs2_v[8*k +: 8];
                end
                else
                begin
                    r.mem_rmask[off+k] = 1'b1;
                    v[8*k +: 8]        = model[base+off+k];
                end
            end
        end
        if (op.mem_read)
        begin
            for (int k = 8 * n; k < 32; k++)
                v[k] = f3[2] ? 1'b0 : v[8*n-1]; // unsigned loads fill with zero
            r.rd_v = v;
        end
        return r;
    endfunction

    // starts on a rising edge and returns on the edge that takes the op
    task automatic issue_op(input rv32i_types::ex_mem_reg_t op, input int cat);
        ex_in <= op;
        @(negedge clk);
        while (stall)
            @(negedge clk);
        @(posedge clk);
        exp_q.push_back(expect_retire(op));
        cat_q.push_back(cat);
        tag = tag + 1'b1;
        if (op.mem_write)
        begin
            for (int k = 0; k < access_bytes(op.funct3); k++)
                model[op.alu_result + k] = op.rs2_v[8*k +: 8];
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want, input int cat);
        checks[cat]++;
        assert (got === want)
        else
        begin
            $display("mismatch %s: got %h, expected %h", name, got, want);
            fails[cat]++;
        end
    endtask

    task automatic check_idle();
        checks[T_RESET]++;
        assert (wb_out.valid === 1'b0 && stall === 1'b0)
        else
        begin
            $display("mismatch wb_out.valid %h, stall %h around reset", wb_out.valid, stall);
            fails[T_RESET]++;
        end
    endtask

    task automatic report_test(input int t, input string name);
        $display("%-22s %0d checks, %0d errors", name, checks[t], fails[t]);
    endtask

    always @(negedge clk)
    begin : retire_check
        rv32i_types::mem_wb_reg_t want;
        int                       cat;
        if (rst === 1'b0 && wb_out.valid === 1'b1)
        begin
            checks[T_ORDER]++;
            assert (exp_q.size() > 0)
            else
            begin
                $display("retire record %h arrived with nothing outstanding", wb_out.order);
                fails[T_ORDER]++;
            end
            if (exp_q.size() > 0)
            begin
                want = exp_q.pop_front();
                cat  = cat_q.pop_front();
                compare_field("wb_out.order", wb_out.order, want.order, T_ORDER);
                compare_field("wb_out.regf_we", wb_out.regf_we, want.regf_we, cat);
                compare_field("wb_out.rd_s", wb_out.rd_s, want.rd_s, cat);
                compare_field("wb_out.rd_v", wb_out.rd_v, want.rd_v, cat);
                compare_field("wb_out.mem_addr", wb_out.mem_addr, want.mem_addr, cat);
                compare_field("wb_out.mem_rmask", wb_out.mem_rmask, want.mem_rmask, cat);
                compare_field("wb_out.mem_wmask", wb_out.mem_wmask, want.mem_wmask, cat);
                compare_field("wb_out.mem_wdata", wb_out.mem_wdata, want.mem_wdata, cat);
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns, operations stopped retiring", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        rv32i_types::ex_mem_reg_t op;
        int                       kind;
        int                       waited;
        int                       errors;
        int                       failed_tests;
        rst   = 1'b1;
        tag   = '0;
        ex_in = make_op(T_LOAD); // a live load waits at the input while reset is held
        @(posedge clk);
        @(negedge clk);
        check_idle();
        @(posedge clk);
        rst   <= 1'b0;           // reset seen at two edges
        ex_in <= '0;
        @(negedge clk);
        check_idle();
        @(posedge clk);
        @(negedge clk);
        check_idle();
        report_test(T_RESET, "reset state");
        @(posedge clk);

        // fill pass so every load has known data
        for (int w = 0; w < `DMEM_WORDS; w++)
        begin
            op            = make_op(T_STORE);
            op.funct3     = rv32i_types::sw;
            op.alu_result = 4 * w;
            issue_op(op, T_STORE);
        end

        for (int i = 0; i < NUM_OPS; i++)
        begin
            kind = T_ALU + next_rand() % 3;
            op   = make_op(kind);
            if (kind == T_LOAD && stored[op.alu_result[31:2]])
                kind = T_RAW;
            if (kind == T_STORE)
                stored[op.alu_result[31:2]] = 1'b1;
            issue_op(op, kind);
        end
        ex_in <= '0;

        waited = 0;
        while (exp_q.size() != 0 && waited < 4 * `DMEM_MAX_LAT)
        begin
            @(negedge clk);
            waited++;
        end
        repeat (4) @(negedge clk); // nothing more may retire while idle

        checks[T_ORDER]++;
        assert (exp_q.size() == 0)
        else
        begin
            $display("%0d operations were lost and never retired", exp_q.size());
            fails[T_ORDER]++;
        end
        report_test(T_ALU, "alu pass-through");
        report_test(T_STORE, "store formatting");
        report_test(T_LOAD, "load extension");
        report_test(T_RAW, "read after write");
        report_test(T_ORDER, "ordering under stall");

        errors       = 0;
        failed_tests = 0;
        for (int t = 0; t < 6; t++)
        begin
            errors       += fails[t];
            failed_tests += (fails[t] != 0);
        end
        $display("summary: 6 tests, %0d failed, %0d errors", failed_tests, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+logic
logic/rv32i_types.sv
logic/dmem_bus_pkg.sv
logic/pipe_reg.sv
logic/mem_stage.sv
logic/data_mem.sv
logic/mem_subsystem.sv
tb/mem_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv32i_types.sv
      - logic/dmem_bus_pkg.sv
      - logic/pipe_reg.sv
      - logic/mem_stage.sv
      - logic/data_mem.sv
      - logic/mem_subsystem.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - tb/mem_subsystem_tb.sv
